/* logic/arm_isa_pkg.sv */
`default_nettype none

package arm_isa_pkg;

	// ======================================
	// instruction classes
	// ======================================
	typedef enum logic [3:0] {
		cls_regop,
		cls_mult,
		cls_swap,
		cls_trans,
		cls_mtrans,
		cls_branch,
		cls_codtrans,
		cls_coregop,
		cls_cortrans,
		cls_swi
	} insn_class_e;

	// ======================================
	// mnemonics, alphabetical
	// ======================================
	typedef enum logic [5:0] {
		mn_adc, mn_add, mn_and, mn_b, mn_bic, mn_bl, mn_cdp,
		mn_cmn, mn_cmp, mn_eor, mn_ldc, mn_ldm, mn_ldr, mn_ldrb,
		mn_mcr, mn_mla, mn_mov, mn_mrc, mn_mul, mn_mvn, mn_orr,
		mn_rsb, mn_rsc, mn_sbc, mn_stc, mn_stm, mn_str, mn_strb,
		mn_sub, mn_swi, mn_swp, mn_swpb, mn_teq, mn_tst,
		mn_unknown
	} mnem_e;

	// data processing opcode field, bits 24:21
	typedef enum logic [3:0] {
		op_and = 4'h0,
		op_eor = 4'h1,
		op_sub = 4'h2,
		op_rsb = 4'h3,
		op_add = 4'h4,
		op_adc = 4'h5,
		op_sbc = 4'h6,
		op_rsc = 4'h7,
		op_tst = 4'h8,
		op_teq = 4'h9,
		op_cmp = 4'ha,
		op_cmn = 4'hb,
		op_orr = 4'hc,
		op_mov = 4'hd,
		op_bic = 4'he,
		op_mvn = 4'hf
	} dp_op_e;

endpackage

`default_nettype wire

/* logic/trace_pkg.sv */
`default_nettype none

package trace_pkg;

	// ======================================
	// record field widths
	// ======================================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// byte lanes of one data word
	localparam int BE_W = DATA_W / 8;

	// ======================================
	// record kinds
	// ======================================
	typedef enum logic {
		rec_instr,
		rec_mem
	} rec_kind_e;

endpackage

`default_nettype wire

/* logic/trace_rec_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface trace_rec_if;
	import trace_pkg::*;
	import arm_isa_pkg::*;

	logic              valid;
	rec_kind_e         kind;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] data;
	logic [BE_W-1:0]   be;
	mnem_e             mnem;
	// undefined for instructions, write for memory
	logic              flag;

	modport src (output valid, kind, addr, data, be, mnem, flag);
	modport dst (input valid, kind, addr, data, be, mnem, flag);

endinterface

`default_nettype wire

/* logic/exec_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_capture (
	input  wire logic                         i_clk,
	input  wire logic                         i_reset,
	input  wire logic                         i_fetch_stall,
	input  wire logic                         i_instruction_valid,
	input  wire logic                         i_instruction_undefined,
	input  wire logic [trace_pkg::DATA_W-1:0] i_instruction,
	input  wire logic [trace_pkg::ADDR_W-1:0] i_instruction_address,
	input  wire logic [2:0]                   i_interrupt,
	trace_rec_if.src                          rec
);
	import trace_pkg::*;
	import arm_isa_pkg::*;

	logic [2:0] interrupt_d1;
	logic       fetch_event;
	logic       irq_clear;

	assign fetch_event = i_instruction_valid && !i_fetch_stall;

	// codes 0 and 7 mean no interrupt is being taken
	assign irq_clear = (interrupt_d1 == 3'd0) || (interrupt_d1 == 3'd7);

	// ======================================
	// interrupt delay and record strobe
	// ======================================
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			interrupt_d1 <= 3'd0;
			rec.valid    <= 1'b0;
		end else begin
			interrupt_d1 <= i_interrupt;
			// a pending interrupt overrides the instruction just starting
			rec.valid    <= fetch_event && irq_clear;
		end
	end

	// ======================================
	// execute stage payload
	// ======================================
	always_ff @(posedge i_clk) begin
		if (fetch_event) begin
			rec.addr <= i_instruction_address;
			rec.data <= i_instruction;
			rec.flag <= i_instruction_undefined;
		end
	end

	// decoder fills in the mnemonic
	assign rec.kind = rec_instr;
	assign rec.mnem = mn_unknown;
	assign rec.be   = {BE_W{1'b1}};

endmodule

`default_nettype wire

/* logic/mem_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_capture (
	input  wire logic                         i_clk,
	input  wire logic                         i_reset,
	input  wire logic                         i_fetch_stall,
	input  wire logic                         i_write_enable,
	input  wire logic                         i_data_access,
	input  wire logic [trace_pkg::ADDR_W-1:0] i_address,
	input  wire logic [trace_pkg::DATA_W-1:0] i_write_data,
	input  wire logic [trace_pkg::DATA_W-1:0] i_read_data,
	input  wire logic [trace_pkg::BE_W-1:0]   i_byte_enable,
	trace_rec_if.src                          rec
);
	import trace_pkg::*;
	import arm_isa_pkg::*;

	logic access;

	assign access = !i_fetch_stall && (i_write_enable || i_data_access);

	always_ff @(posedge i_clk) begin
		if (i_reset)
			rec.valid <= 1'b0;
		else
			rec.valid <= access;
	end

	// write wins when both strobes are high
	always_ff @(posedge i_clk) begin
		if (access) begin
			rec.addr <= i_address;
			rec.flag <= i_write_enable;
			if (i_write_enable) begin
				rec.data <= i_write_data;
				rec.be   <= i_byte_enable;
			end else begin
				rec.data <= i_read_data;
				rec.be   <= {BE_W{1'b1}};
			end
		end
	end

	assign rec.kind = rec_mem;
	assign rec.mnem = mn_unknown;

endmodule

`default_nettype wire

/* logic/insn_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
	input  wire logic i_clk,
	input  wire logic i_reset,
	trace_rec_if.dst  rec_in,
	trace_rec_if.src  rec_out
);
	import trace_pkg::*;
	import arm_isa_pkg::*;

	logic [DATA_W-1:0] insn;
	dp_op_e            opcode;
	insn_class_e       insn_class;
	mnem_e             mnem;

	assign insn   = rec_in.data;
	assign opcode = dp_op_e'(insn[24:21]);

	// ======================================
	// class match, order matters
	// ======================================
	always_comb begin
		// swap and mult both look like regop, so test them first
		if ({insn[27:23], insn[21:20], insn[11:4]} == {5'b00010, 2'b00, 8'b0000_1001})
			insn_class = cls_swap;
		else if ({insn[27:22], insn[7:4]} == {6'b000000, 4'b1001})
			insn_class = cls_mult;
		else if (insn[27:26] == 2'b00)
			insn_class = cls_regop;
		else if (insn[27:26] == 2'b01)
			insn_class = cls_trans;
		else if (insn[27:25] == 3'b100)
			insn_class = cls_mtrans;
		else if (insn[27:25] == 3'b101)
			insn_class = cls_branch;
		else if (insn[27:25] == 3'b110)
			insn_class = cls_codtrans;
		else if ({insn[27:24], insn[4]} == {4'b1110, 1'b0})
			insn_class = cls_coregop;
		else if ({insn[27:24], insn[4]} == {4'b1110, 1'b1})
			insn_class = cls_cortrans;
		else
			insn_class = cls_swi;
	end

	// ======================================
	// mnemonic select
	// ======================================
	always_comb begin
		mnem = mn_unknown;
		case (insn_class)
			cls_regop: begin
				case (opcode)
					op_and: mnem = mn_and;
					op_eor: mnem = mn_eor;
					op_sub: mnem = mn_sub;
					op_rsb: mnem = mn_rsb;
					op_add: mnem = mn_add;
					op_adc: mnem = mn_adc;
					op_sbc: mnem = mn_sbc;
					op_rsc: mnem = mn_rsc;
					op_tst: mnem = mn_tst;
					op_teq: mnem = mn_teq;
					op_cmp: mnem = mn_cmp;
					op_cmn: mnem = mn_cmn;
					op_orr: mnem = mn_orr;
					op_mov: mnem = mn_mov;
					op_bic: mnem = mn_bic;
					op_mvn: mnem = mn_mvn;
					default: mnem = mn_unknown;
				endcase
			end
			// A bit picks accumulate
			cls_mult:     mnem = insn[21] ? mn_mla : mn_mul;
			cls_swap:     mnem = insn[22] ? mn_swpb : mn_swp;
			cls_trans: begin
				// B bit and L bit
				case ({insn[22], insn[20]})
					2'b00: mnem = mn_str;
					2'b01: mnem = mn_ldr;
					2'b10: mnem = mn_strb;
					2'b11: mnem = mn_ldrb;
					default: mnem = mn_unknown;
				endcase
			end
			cls_mtrans:   mnem = insn[20] ? mn_ldm : mn_stm;
			cls_branch:   mnem = insn[24] ? mn_bl : mn_b;
			cls_codtrans: mnem = insn[20] ? mn_ldc : mn_stc;
			cls_coregop:  mnem = mn_cdp;
			cls_cortrans: mnem = insn[20] ? mn_mrc : mn_mcr;
			cls_swi:      mnem = mn_swi;
			default:      mnem = mn_unknown;
		endcase
	end

	// ======================================
	// output register
	// ======================================
	always_ff @(posedge i_clk) begin
		if (i_reset)
			rec_out.valid <= 1'b0;
		else
			rec_out.valid <= rec_in.valid;
	end

	always_ff @(posedge i_clk) begin
		if (rec_in.valid) begin
			rec_out.addr <= rec_in.addr;
			rec_out.data <= rec_in.data;
			rec_out.be   <= rec_in.be;
			rec_out.flag <= rec_in.flag;
			rec_out.mnem <= mnem;
		end
	end

	assign rec_out.kind = rec_instr;

endmodule

`default_nettype wire

/* logic/trace_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_merge #(
	parameter int MEM_Q_DEPTH = 4
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_reset,
	trace_rec_if.dst                           ins,
	trace_rec_if.dst                           mem,
	output      logic                          o_trace_valid,
	output      trace_pkg::rec_kind_e          o_trace_kind,
	output      logic [trace_pkg::ADDR_W-1:0]  o_trace_addr,
	output      logic [trace_pkg::DATA_W-1:0]  o_trace_data,
	output      logic [trace_pkg::BE_W-1:0]    o_trace_be,
	output      arm_isa_pkg::mnem_e            o_trace_mnem,
	output      logic                          o_trace_flag,
	output      logic                          o_overflow
);
	import trace_pkg::*;
	import arm_isa_pkg::*;

	localparam int PTR_W = $clog2(MEM_Q_DEPTH);

	// memory record queue storage
	logic [ADDR_W-1:0] q_addr [MEM_Q_DEPTH];
	logic [DATA_W-1:0] q_data [MEM_Q_DEPTH];
	logic [BE_W-1:0]   q_be   [MEM_Q_DEPTH];
	logic              q_flag [MEM_Q_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             q_empty;
	logic             q_full;
	logic             pop;
	logic             push;
	logic             bypass;
	logic             drop;

	assign q_empty = (count == '0);
	assign q_full  = (count == (PTR_W + 1)'(MEM_Q_DEPTH));

	// ======================================
	// arbitration, instructions first
	// ======================================
	assign pop    = !ins.valid && !q_empty;
	// empty queue lets a memory record straight through
	assign bypass = !ins.valid && q_empty && mem.valid;
	assign push   = mem.valid && !bypass && (!q_full || pop);
	assign drop   = mem.valid && q_full && !pop;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			o_overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// sticky until reset
			if (drop)
				o_overflow <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (push) begin
			q_addr[wr_ptr] <= mem.addr;
			q_data[wr_ptr] <= mem.data;
			q_be[wr_ptr]   <= mem.be;
			q_flag[wr_ptr] <= mem.flag;
		end
	end

	// ======================================
	// output register
	// ======================================
	always_ff @(posedge i_clk) begin
		if (i_reset)
			o_trace_valid <= 1'b0;
		else
			o_trace_valid <= ins.valid || pop || bypass;
	end

	always_ff @(posedge i_clk) begin
		if (ins.valid) begin
			o_trace_kind <= ins.kind;
			o_trace_addr <= ins.addr;
			o_trace_data <= ins.data;
			o_trace_be   <= ins.be;
			o_trace_mnem <= ins.mnem;
			o_trace_flag <= ins.flag;
		end else if (pop) begin
			o_trace_kind <= rec_mem;
			o_trace_addr <= q_addr[rd_ptr];
			o_trace_data <= q_data[rd_ptr];
			o_trace_be   <= q_be[rd_ptr];
			o_trace_mnem <= mn_unknown;
			o_trace_flag <= q_flag[rd_ptr];
		end else if (bypass) begin
			o_trace_kind <= mem.kind;
			o_trace_addr <= mem.addr;
			o_trace_data <= mem.data;
			o_trace_be   <= mem.be;
			o_trace_mnem <= mem.mnem;
			o_trace_flag <= mem.flag;
		end
	end

endmodule

`default_nettype wire

/* logic/a23_tracer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module a23_tracer_top #(
	parameter int MEM_Q_DEPTH = 4
) (
	input  wire logic                         i_clk,
	input  wire logic                         i_reset,
	// fetch side
	input  wire logic                         i_fetch_stall,
	input  wire logic                         i_instruction_valid,
	input  wire logic                         i_instruction_undefined,
	input  wire logic [trace_pkg::DATA_W-1:0] i_instruction,
	input  wire logic [trace_pkg::ADDR_W-1:0] i_instruction_address,
	input  wire logic [2:0]                   i_interrupt,
	// data side
	input  wire logic                         i_write_enable,
	input  wire logic                         i_data_access,
	input  wire logic [trace_pkg::ADDR_W-1:0] i_address,
	input  wire logic [trace_pkg::DATA_W-1:0] i_write_data,
	input  wire logic [trace_pkg::DATA_W-1:0] i_read_data,
	input  wire logic [trace_pkg::BE_W-1:0]   i_byte_enable,
	// trace stream
	output      logic                         o_trace_valid,
	output      trace_pkg::rec_kind_e         o_trace_kind,
	output      logic [trace_pkg::ADDR_W-1:0] o_trace_addr,
	output      logic [trace_pkg::DATA_W-1:0] o_trace_data,
	output      logic [trace_pkg::BE_W-1:0]   o_trace_be,
	output      arm_isa_pkg::mnem_e           o_trace_mnem,
	output      logic                         o_trace_flag,
	output      logic                         o_overflow
);

	trace_rec_if exec_rec ();
	trace_rec_if insn_rec ();
	trace_rec_if mem_rec ();

	// ======================================
	// input side
	// ======================================
	exec_capture u_exec_capture (
		.i_clk                  (i_clk),
		.i_reset                (i_reset),
		.i_fetch_stall          (i_fetch_stall),
		.i_instruction_valid    (i_instruction_valid),
		.i_instruction_undefined(i_instruction_undefined),
		.i_instruction          (i_instruction),
		.i_instruction_address  (i_instruction_address),
		.i_interrupt            (i_interrupt),
		.rec                    (exec_rec.src)
	);

	mem_capture u_mem_capture (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_fetch_stall (i_fetch_stall),
		.i_write_enable(i_write_enable),
		.i_data_access (i_data_access),
		.i_address     (i_address),
		.i_write_data  (i_write_data),
		.i_read_data   (i_read_data),
		.i_byte_enable (i_byte_enable),
		.rec           (mem_rec.src)
	);

	// ======================================
	// decode and merge
	// ======================================
	insn_decoder u_insn_decoder (
		.i_clk  (i_clk),
		.i_reset(i_reset),
		.rec_in (exec_rec.dst),
		.rec_out(insn_rec.src)
	);

	trace_merge #(
		.MEM_Q_DEPTH(MEM_Q_DEPTH)
	) u_trace_merge (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.ins          (insn_rec.dst),
		.mem          (mem_rec.dst),
		.o_trace_valid(o_trace_valid),
		.o_trace_kind (o_trace_kind),
		.o_trace_addr (o_trace_addr),
		.o_trace_data (o_trace_data),
		.o_trace_be   (o_trace_be),
		.o_trace_mnem (o_trace_mnem),
		.o_trace_flag (o_trace_flag),
		.o_overflow   (o_overflow)
	);

endmodule

`default_nettype wire

/* dv/tb_a23_tracer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_a23_tracer;
	import trace_pkg::*;
	import arm_isa_pkg::*;

	localparam int MEM_Q_DEPTH  = 4;
	localparam int N_DIRECTED   = 34;
	localparam int N_RANDOM     = 200;
	localparam int N_MEM        = 100;
	localparam int N_BURST      = 40;
	localparam int N_MIX        = 60;
	localparam int TOTAL_CYCLES = 8 + 2 * N_DIRECTED + N_RANDOM + 16 + N_MEM + 2
		+ N_BURST + 9 + N_MIX + 20;
	localparam int CYCLE_LIMIT  = 10 * TOTAL_CYCLES + 100;

	// one encoding per mnemonic, first sixteen in data processing opcode order
	localparam logic [31:0] DIR_WORD [N_DIRECTED] = '{
		32'he0010002, 32'he0210002, 32'he0410002, 32'he0610002,
		32'he0810002, 32'he0a10002, 32'he0c10002, 32'he0e10002,
		32'he1010002, 32'he1210002, 32'he1410002, 32'he1610002,
		32'he1810002, 32'he1a10002, 32'he1c10002, 32'he1e10002,
		32'he0000091, 32'he0200091, 32'he1000091, 32'he1400091,
		32'he5800000, 32'he5900000, 32'he5c00000, 32'he5d00000,
		32'he8800003, 32'he8900003, 32'hea000010, 32'heb000010,
		32'hed800000, 32'hed900000, 32'hee000000, 32'hee000010,
		32'hee100010, 32'hef000000
	};
	localparam mnem_e DIR_MNEM [N_DIRECTED] = '{
		mn_and, mn_eor, mn_sub, mn_rsb, mn_add, mn_adc, mn_sbc, mn_rsc,
		mn_tst, mn_teq, mn_cmp, mn_cmn, mn_orr, mn_mov, mn_bic, mn_mvn,
		mn_mul, mn_mla, mn_swp, mn_swpb, mn_str, mn_ldr, mn_strb, mn_ldrb,
		mn_stm, mn_ldm, mn_b, mn_bl, mn_stc, mn_ldc, mn_cdp, mn_mcr,
		mn_mrc, mn_swi
	};

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		mnem_e       mnem;
		logic        undef;
		int          cyc;
	} ins_exp_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  be;
		logic        write;
	} mem_exp_t;

	logic        i_clk = 1'b0;
	logic        i_reset;
	logic        i_fetch_stall;
	logic        i_instruction_valid;
	logic        i_instruction_undefined;
	logic [31:0] i_instruction;
	logic [31:0] i_instruction_address;
	logic [2:0]  i_interrupt;
	logic        i_write_enable;
	logic        i_data_access;
	logic [31:0] i_address;
	logic [31:0] i_write_data;
	logic [31:0] i_read_data;
	logic [3:0]  i_byte_enable;
	logic        o_trace_valid;
	rec_kind_e   o_trace_kind;
	logic [31:0] o_trace_addr;
	logic [31:0] o_trace_data;
	logic [3:0]  o_trace_be;
	mnem_e       o_trace_mnem;
	logic        o_trace_flag;
	logic        o_overflow;

	// scoreboard and reference model state
	ins_exp_t    exp_ins_q [$];
	mem_exp_t    exp_mem_q [$];
	mem_exp_t    mem_d1_rec;
	logic        ins_d1;
	logic        ins_d2;
	logic        mem_d1;
	logic        exp_ovf;
	logic [2:0]  prev_irq;
	int          q_occ;
	logic        fixed_valid;
	mnem_e       fixed_mnem;
	string       test_name;
	logic [31:0] seed = 32'h7cffe752;
	logic [31:0] r;
	int          errors;
	int          records;
	int          drops;
	int          cyc;

	a23_tracer_top #(
		.MEM_Q_DEPTH(MEM_Q_DEPTH)
	) UUT (
		.i_clk                  (i_clk),
		.i_reset                (i_reset),
		.i_fetch_stall          (i_fetch_stall),
		.i_instruction_valid    (i_instruction_valid),
		.i_instruction_undefined(i_instruction_undefined),
		.i_instruction          (i_instruction),
		.i_instruction_address  (i_instruction_address),
		.i_interrupt            (i_interrupt),
		.i_write_enable         (i_write_enable),
		.i_data_access          (i_data_access),
		.i_address              (i_address),
		.i_write_data           (i_write_data),
		.i_read_data            (i_read_data),
		.i_byte_enable          (i_byte_enable),
		.o_trace_valid          (o_trace_valid),
		.o_trace_kind           (o_trace_kind),
		.o_trace_addr           (o_trace_addr),
		.o_trace_data           (o_trace_data),
		.o_trace_be             (o_trace_be),
		.o_trace_mnem           (o_trace_mnem),
		.o_trace_flag           (o_trace_flag),
		.o_overflow             (o_overflow)
	);

	initial begin
		forever #2 i_clk = ~i_clk;
	end

	// ========================================
	// reference model
	// ========================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		seed = xorshift(seed);
		return seed;
	endfunction

	// swap and mult are carved out of the regop space first
	function automatic mnem_e ref_mnem(input logic [31:0] w);
		if (w[27:23] == 5'b00010 && w[21:20] == 2'b00 && w[11:4] == 8'h09)
			return w[22] ? mn_swpb : mn_swp;
		if (w[27:22] == 6'b000000 && w[7:4] == 4'h9)
			return w[21] ? mn_mla : mn_mul;
		case (w[27:25])
			3'b000, 3'b001: return DIR_MNEM[w[24:21]];
			3'b010, 3'b011: begin
				if (w[22])
					return w[20] ? mn_ldrb : mn_strb;
				return w[20] ? mn_ldr : mn_str;
			end
			3'b100: return w[20] ? mn_ldm : mn_stm;
			3'b101: return w[24] ? mn_bl : mn_b;
			3'b110: return w[20] ? mn_ldc : mn_stc;
			default: begin
				if (w[24])
					return mn_swi;
				if (!w[4])
					return mn_cdp;
				return w[20] ? mn_mrc : mn_mcr;
			end
		endcase
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		errors++;
		$display("error %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
	endtask

	task automatic check_output();
		ins_exp_t ie;
		mem_exp_t me;
		assert (o_overflow == exp_ovf)
			else report_mismatch("overflow", 32'(exp_ovf), 32'(o_overflow));
		if (o_trace_valid) begin
			records++;
			if (o_trace_kind == rec_instr && exp_ins_q.size() == 0) begin
				errors++;
				$display("unexpected instruction record at cycle %0d in %s", cyc, test_name);
			end else if (o_trace_kind == rec_instr) begin
				ie = exp_ins_q.pop_front();
				assert (cyc == ie.cyc) else report_mismatch("instr cycle", ie.cyc, cyc);
				assert (o_trace_addr == ie.addr)
					else report_mismatch("instr addr", ie.addr, o_trace_addr);
				assert (o_trace_data == ie.data)
					else report_mismatch("instr word", ie.data, o_trace_data);
				assert (o_trace_mnem == ie.mnem)
					else report_mismatch("mnem", 32'(ie.mnem), 32'(o_trace_mnem));
				assert (o_trace_flag == ie.undef)
					else report_mismatch("undefined", 32'(ie.undef), 32'(o_trace_flag));
			end else if (exp_mem_q.size() == 0) begin
				errors++;
				$display("unexpected memory record at cycle %0d in %s", cyc, test_name);
			end else begin
				me = exp_mem_q.pop_front();
				assert (o_trace_addr == me.addr)
					else report_mismatch("mem addr", me.addr, o_trace_addr);
				assert (o_trace_data == me.data)
					else report_mismatch("mem data", me.data, o_trace_data);
				assert (o_trace_be == me.be)
					else report_mismatch("byte enables", 32'(me.be), 32'(o_trace_be));
				assert (o_trace_flag == me.write)
					else report_mismatch("write", 32'(me.write), 32'(o_trace_flag));
			end
		end
	endtask

	// queue occupancy, head leaves only when no instruction goes out
	task automatic model_merge();
		logic drop;
		drop = mem_d1 && ins_d2 && (q_occ == MEM_Q_DEPTH);
		if (drop) begin
			exp_ovf = 1'b1;
			drops++;
		end else if (mem_d1) begin
			exp_mem_q.push_back(mem_d1_rec);
		end
		if (ins_d2 && mem_d1 && !drop)
			q_occ++;
		else if (!ins_d2 && q_occ > 0 && !mem_d1)
			q_occ--;
	endtask

	task automatic capture_inputs();
		logic ok;
		ins_exp_t ie;
		ok = i_instruction_valid && !i_fetch_stall && (prev_irq == 3'd0 || prev_irq == 3'd7);
		if (ok) begin
			ie.addr  = i_instruction_address;
			ie.data  = i_instruction;
			ie.mnem  = fixed_valid ? fixed_mnem : ref_mnem(i_instruction);
			ie.undef = i_instruction_undefined;
			ie.cyc   = cyc + 3;
			exp_ins_q.push_back(ie);
		end
		ins_d2 = ins_d1;
		ins_d1 = ok;
		mem_d1 = !i_fetch_stall && (i_write_enable || i_data_access);
		mem_d1_rec.addr  = i_address;
		mem_d1_rec.write = i_write_enable;
		mem_d1_rec.data  = i_write_enable ? i_write_data : i_read_data;
		mem_d1_rec.be    = i_write_enable ? i_byte_enable : 4'hf;
		prev_irq = i_interrupt;
	endtask

	// inputs and outputs are both settled at the falling edge
	always @(negedge i_clk) begin
		if (i_reset) begin
			// reset flushes every record still in flight
			exp_ins_q.delete();
			exp_mem_q.delete();
			ins_d1   = 1'b0;
			ins_d2   = 1'b0;
			mem_d1   = 1'b0;
			exp_ovf  = 1'b0;
			prev_irq = 3'd0;
			q_occ    = 0;
		end else begin
			check_output();
			model_merge();
			capture_inputs();
		end
	end

	always @(posedge i_clk) begin
		cyc++;
		if (cyc >= CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, %0d instruction and %0d memory records pending",
				cyc, exp_ins_q.size(), exp_mem_q.size());
			$display("TEST FAILED");
			$finish;
		end
	end

	// ========================================
	// stimulus
	// ========================================
	task automatic step();
		@(posedge i_clk);
		#1;
	endtask

	task automatic idle();
		i_fetch_stall       = 1'b0;
		i_instruction_valid = 1'b0;
		i_interrupt         = 3'd0;
		i_write_enable      = 1'b0;
		i_data_access       = 1'b0;
		fixed_valid         = 1'b0;
	endtask

	task automatic fetch(input logic [31:0] word);
		i_instruction_valid     = 1'b1;
		i_instruction           = word;
		i_instruction_address   = rand32() & 32'hffff_fffc;
		i_instruction_undefined = ^rand32();
	endtask

	task automatic mem_access(input logic wr, input logic rd);
		i_write_enable = wr;
		i_data_access  = rd;
		i_address      = rand32();
		i_write_data   = rand32();
		i_read_data    = rand32();
		i_byte_enable  = 4'(rand32());
	endtask

	task automatic apply_reset();
		i_reset = 1'b1;
		idle();
		repeat (8) step();
		i_reset = 1'b0;
		@(negedge i_clk);
		assert (!o_trace_valid && !o_overflow)
			else begin
				errors++;
				$display("trace valid or overflow still high after reset");
			end
	endtask

	initial begin
		errors                  = 0;
		records                 = 0;
		drops                   = 0;
		cyc                     = 0;
		i_instruction           = '0;
		i_instruction_address   = '0;
		i_instruction_undefined = 1'b0;
		i_address               = '0;
		i_write_data            = '0;
		i_read_data             = '0;
		i_byte_enable           = '0;
		fixed_mnem              = mn_unknown;
		test_name               = "reset";
		apply_reset();

		test_name = "directed decode";
		for (int i = 0; i < N_DIRECTED; i++) begin
			step();
			fetch(DIR_WORD[i]);
			fixed_valid = 1'b1;
			fixed_mnem  = DIR_MNEM[i];
			step();
			idle();
		end

		test_name = "random decode";
		for (int i = 0; i < N_RANDOM; i++) begin
			step();
			idle();
			r = rand32();
			if (r[1:0] != 2'b00)
				fetch(rand32());
			i_fetch_stall = (r[3:2] == 2'b00);
		end

		// code held one cycle ahead of the fetch it should block
		test_name = "interrupt";
		for (int k = 0; k < 8; k++) begin
			step();
			idle();
			i_interrupt = 3'(k);
			step();
			idle();
			fetch(rand32());
		end

		test_name = "memory";
		step();
		idle();
		mem_access(1'b1, 1'b1);
		for (int i = 0; i < N_MEM; i++) begin
			step();
			idle();
			r = rand32();
			if (r[1:0] != 2'b00)
				mem_access(r[2], r[3]);
			i_fetch_stall = (r[5:4] == 2'b00);
		end

		test_name = "overflow burst";
		step();
		idle();
		assert (!o_overflow) else report_mismatch("overflow before burst", 0, 32'(o_overflow));
		for (int i = 0; i < N_BURST; i++) begin
			step();
			idle();
			fetch(rand32());
			r = rand32();
			if (i >= 4 && i < 8 + MEM_Q_DEPTH)
				mem_access(r[0], !r[0]);
		end
		assert (o_overflow) else report_mismatch("overflow after burst", 1, 32'(o_overflow));

		// queue is still full here, reset must empty it and clear overflow
		test_name = "reset after overflow";
		apply_reset();

		test_name = "merge mix";
		for (int i = 0; i < N_MIX; i++) begin
			step();
			idle();
			r = rand32();
			if (r[2:0] != 3'd0)
				fetch(rand32());
			if (i % 12 < 4)
				mem_access(r[3], !r[3]);
		end

		test_name = "drain";
		step();
		idle();
		repeat (4) step();
		while (exp_ins_q.size() != 0 || exp_mem_q.size() != 0)
			@(posedge i_clk);
		repeat (8) step();

		$display("records %0d, dropped %0d, errors %0d", records, drops, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
logic/arm_isa_pkg.sv
logic/trace_pkg.sv
logic/trace_rec_if.sv
logic/exec_capture.sv
logic/mem_capture.sv
logic/insn_decoder.sv
logic/trace_merge.sv
logic/a23_tracer_top.sv
dv/tb_a23_tracer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the tracer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_a23_tracer -f src.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }

grep -q "^TEST PASSED$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
